/* hdl/uvispace_cfg.svh */
`ifndef UVISPACE_CFG_SVH
`define UVISPACE_CFG_SVH

// ====================
// Pixel widths
// ====================
`define PIX_W        12     // Raw camera sample and RGB channel
`define CH_W         8      // Channel width after truncation

// ====================
// Line buffer and sync
// ====================
`define MAX_WIDTH    64     // Raw columns per line, max
`define COL_W        6      // Enough for MAX_WIDTH columns
`define SYNC_FRAMES  2      // Frame ends dropped after reset

// Frame-rate window, one second at 50 MHz
`define RATE_TICKS   50000000
`define RATE_W       32

`endif

/* hdl/video_pkg.sv */
`default_nettype none

`include "uvispace_cfg.svh"

package video_pkg;

  // One raw Bayer sample straight off the sensor
  typedef logic [`PIX_W-1:0] raw_pix_t;

  // Column position within a line
  typedef logic [`COL_W-1:0] col_t;

  // Processed channel, top bits of a raw sample
  typedef logic [`CH_W-1:0] chan8_t;

  // Full-width colour pixel after the 2x2 merge
  typedef struct packed {
    raw_pix_t red;
    raw_pix_t green;
    raw_pix_t blue;
  } rgb12_t;

endpackage

`default_nettype wire

/* hdl/ctrl_pkg.sv */
`default_nettype none

`include "uvispace_cfg.svh"

package ctrl_pkg;
  import video_pkg::*;

  localparam int NUM_CH = 3;  // R, G, B

  // Inclusive threshold window for one channel
  typedef struct packed {
    chan8_t lo;
    chan8_t hi;
  } window_t;

  // Frames counted per rate window
  typedef logic [`RATE_W-1:0] rate_t;

endpackage

`default_nettype wire

/* hdl/video_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Raw sample stream, capture to Bayer stage
interface raw_pix_if import video_pkg::*; ();
  raw_pix_t pix;
  logic     valid;     // One strobe per accepted sample
  col_t     col;       // Column of this sample within the line
  logic     row_odd;   // High on B/G2 rows

  modport src (output pix, valid, col, row_odd);
  modport snk (input pix, valid, col, row_odd);
endinterface

// Merged RGB pixel stream
interface rgb_if import video_pkg::*; ();
  raw_pix_t red;
  raw_pix_t green;
  raw_pix_t blue;
  logic     valid;     // One strobe per 2x2 block

  modport src (output red, green, blue, valid);
  modport snk (input red, green, blue, valid);
endinterface

`default_nettype wire

/* hdl/pixel_capture.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uvispace_cfg.svh"

module pixel_capture
  import video_pkg::*;
(
  input  wire           CLOCK_50,
  input  wire           rst_n,
  input  wire raw_pix_t cam_pix,
  input  wire           cam_lval,
  input  wire           cam_fval,
  input  wire           capture_en,
  raw_pix_if.src        raw,
  output logic          eof
);

  localparam int SYNC_W = $clog2(`SYNC_FRAMES + 1);

  raw_pix_t          pix_q;
  logic              lval_q, fval_q;   // Registered strobes
  logic              lval_d, fval_d;   // One cycle older, for edges
  logic [SYNC_W-1:0] sync_cnt;
  logic              sync_done;
  logic              accept;
  col_t              col_q;
  logic              row_odd_q;

  // ====================
  // Input registers
  // ====================
  always_ff @(posedge CLOCK_50 or negedge rst_n) begin
    if (!rst_n) begin
      lval_q <= 1'b0;
      fval_q <= 1'b0;
      lval_d <= 1'b0;
      fval_d <= 1'b0;
    end else begin
      lval_q <= cam_lval;
      fval_q <= cam_fval;
      lval_d <= lval_q;
      fval_d <= fval_q;
    end
  end

  always_ff @(posedge CLOCK_50) begin
    pix_q <= cam_pix;
  end

  assign eof = fval_d & ~fval_q;   // Frame valid falling edge

  // ====================
  // Frame sync
  // ====================
  // Counts frame ends, then saturates; sync_done can only rise with
  // frame valid low, so the first forwarded pixel starts a frame
  always_ff @(posedge CLOCK_50 or negedge rst_n) begin
    if (!rst_n)
      sync_cnt <= '0;
    else if (eof && !sync_done)
      sync_cnt <= sync_cnt + 1'b1;
  end

  assign sync_done = (sync_cnt == SYNC_W'(`SYNC_FRAMES));
  assign accept    = lval_q & fval_q & capture_en & sync_done;

  // Column and row parity
  always_ff @(posedge CLOCK_50 or negedge rst_n) begin
    if (!rst_n) begin
      col_q     <= '0;
      row_odd_q <= 1'b0;
    end else begin
      if (!lval_q)
        col_q <= '0;                    // Restart every line
      else if (accept)
        col_q <= col_q + 1'b1;
      if (!fval_q)
        row_odd_q <= 1'b0;              // Frames start on a G1/R row
      else if (lval_d && !lval_q)
        row_odd_q <= ~row_odd_q;        // Line end
    end
  end

  assign raw.pix     = pix_q;
  assign raw.valid   = accept;
  assign raw.col     = col_q;
  assign raw.row_odd = row_odd_q;

  // No more samples once the last buffer column is taken
  a_col_range : assert property (@(posedge CLOCK_50) disable iff (!rst_n)
    (accept && col_q == col_t'(`MAX_WIDTH - 1)) |=> !accept);

endmodule

`default_nettype wire

/* hdl/bayer_to_rgb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uvispace_cfg.svh"

module bayer_to_rgb
  import video_pkg::*;
(
  input  wire    CLOCK_50,
  input  wire    rst_n,
  raw_pix_if.snk raw,
  rgb_if.src     rgb
);

  // Even row (G1 R G1 R ...) kept until the matching odd row
  raw_pix_t        line_buf [`MAX_WIDTH];
  raw_pix_t        blue_hold;            // B from the current odd row
  col_t            col_pair;             // Even column of the block
  logic [`PIX_W:0] green_sum;            // One extra bit for the carry
  logic            even_wr;
  logic            blue_wr;
  logic            block_end;
  rgb12_t          rgb_q;
  logic            valid_q;

  // ====================
  // Block decode
  // ====================
  assign col_pair  = {raw.col[`COL_W-1:1], 1'b0};
  assign even_wr   = raw.valid & ~raw.row_odd;
  assign blue_wr   = raw.valid & raw.row_odd & ~raw.col[0];
  assign block_end = raw.valid & raw.row_odd & raw.col[0];   // G2 closes the block

  // G1 from the buffer, G2 is the live sample
  assign green_sum = {1'b0, line_buf[col_pair]} + {1'b0, raw.pix};

  // Line buffer write
  always_ff @(posedge CLOCK_50) begin
    if (even_wr)
      line_buf[raw.col] <= raw.pix;
  end

  // ====================
  // Merge
  // ====================
  always_ff @(posedge CLOCK_50) begin
    if (blue_wr)
      blue_hold <= raw.pix;
    if (block_end) begin
      rgb_q.red   <= line_buf[raw.col];      // R sat above G2
      rgb_q.green <= green_sum[`PIX_W:1];    // Mean of both greens
      rgb_q.blue  <= blue_hold;
    end
  end

  always_ff @(posedge CLOCK_50 or negedge rst_n) begin
    if (!rst_n)
      valid_q <= 1'b0;
    else
      valid_q <= block_end;
  end

  assign rgb.red   = rgb_q.red;
  assign rgb.green = rgb_q.green;
  assign rgb.blue  = rgb_q.blue;
  assign rgb.valid = valid_q;

  // One strobe per 2x2 block, never on two cycles in a row
  a_block_end : assert property (@(posedge CLOCK_50) disable iff (!rst_n)
    valid_q |=> !valid_q);

endmodule

`default_nettype wire

/* hdl/channel_window.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uvispace_cfg.svh"

module channel_window
  import video_pkg::*;
  import ctrl_pkg::*;
(
  input  wire           CLOCK_50,
  input  wire           rst_n,
  input  wire raw_pix_t chan,
  input  wire           valid,
  input  wire window_t  win,
  output chan8_t        value,
  output logic          in_win
);

  chan8_t top_bits;

  assign top_bits = chan[`PIX_W-1 -: `CH_W];   // Drop the low sensor bits

  always_ff @(posedge CLOCK_50) begin
    if (valid)
      value <= top_bits;
  end

  // Inclusive at both ends
  always_ff @(posedge CLOCK_50 or negedge rst_n) begin
    if (!rst_n)
      in_win <= 1'b0;
    else if (valid)
      in_win <= (top_bits >= win.lo) && (top_bits <= win.hi);
  end

endmodule

`default_nettype wire

/* hdl/pixel_classifier.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uvispace_cfg.svh"

module pixel_classifier
  import video_pkg::*;
  import ctrl_pkg::*;
(
  input  wire              CLOCK_50,
  input  wire              rst_n,
  rgb_if.snk               rgb,
  input  wire chan8_t      value [NUM_CH],   // R, G, B order
  input  wire [NUM_CH-1:0] in_win,
  output chan8_t           gray,
  output logic             gray_valid,
  output chan8_t           bin8,
  output logic             bin_valid
);

  logic [`CH_W+1:0] gray_sum;   // R + 2G + B, max 1020
  logic [1:0]       valid_d;    // [0] window stage, [1] this stage

  assign gray_sum = {2'b00, value[0]} + {1'b0, value[1], 1'b0} + {2'b00, value[2]};

  always_ff @(posedge CLOCK_50) begin
    if (valid_d[0]) begin
      gray <= gray_sum[`CH_W+1:2];
      bin8 <= (&in_win) ? {`CH_W{1'b1}} : '0;   // All three channels hit
    end
  end

  // Valid trails the rgb strobe by two stages
  always_ff @(posedge CLOCK_50 or negedge rst_n) begin
    if (!rst_n)
      valid_d <= '0;
    else
      valid_d <= {valid_d[0], rgb.valid};
  end

  assign gray_valid = valid_d[1];
  assign bin_valid  = valid_d[1];

endmodule

`default_nettype wire

/* hdl/rate_meter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uvispace_cfg.svh"

module rate_meter
  import ctrl_pkg::*;
#(
  parameter int TICKS = `RATE_TICKS
) (
  input  wire  CLOCK_50,
  input  wire  rst_n,
  input  wire  eof,
  output rate_t rate,
  output logic pulse_led
);

  localparam int TICK_W = $clog2(TICKS);

  logic [TICK_W-1:0] tick_cnt;
  rate_t             frame_cnt;   // Frame ends in the open window
  logic              win_end;

  assign win_end = (tick_cnt == TICK_W'(TICKS - 1));

  always_ff @(posedge CLOCK_50 or negedge rst_n) begin
    if (!rst_n) begin
      tick_cnt  <= '0;
      frame_cnt <= '0;
      rate      <= '0;
      pulse_led <= 1'b0;
    end else if (win_end) begin
      tick_cnt  <= '0;
      rate      <= frame_cnt + rate_t'(eof);   // Last-cycle eof still counts
      frame_cnt <= '0;
      pulse_led <= ~pulse_led;
    end else begin
      tick_cnt  <= tick_cnt + 1'b1;
      frame_cnt <= frame_cnt + rate_t'(eof);
    end
  end

  // Counter never rolls over inside a window
  a_no_wrap : assert property (@(posedge CLOCK_50) disable iff (!rst_n)
    (eof && !win_end) |=> (frame_cnt != '0));

endmodule

`default_nettype wire

/* hdl/uvispace_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uvispace_cfg.svh"

module uvispace_top
  import video_pkg::*;
  import ctrl_pkg::*;
#(
  parameter int TICKS = `RATE_TICKS
) (
  input  wire               CLOCK_50,
  input  wire               rst_n,
  input  wire [`PIX_W-1:0]  cam_pix,
  input  wire               cam_lval,
  input  wire               cam_fval,
  input  wire               capture_en,
  input  wire [`CH_W-1:0]   red_lo,
  input  wire [`CH_W-1:0]   red_hi,
  input  wire [`CH_W-1:0]   green_lo,
  input  wire [`CH_W-1:0]   green_hi,
  input  wire [`CH_W-1:0]   blue_lo,
  input  wire [`CH_W-1:0]   blue_hi,
  output logic [`PIX_W-1:0] rgb_red,
  output logic [`PIX_W-1:0] rgb_green,
  output logic [`PIX_W-1:0] rgb_blue,
  output logic              rgb_valid,
  output logic [`CH_W-1:0]  gray,
  output logic              gray_valid,
  output logic [`CH_W-1:0]  bin8,
  output logic              bin_valid,
  output logic [`RATE_W-1:0] rate,
  output logic              pulse_led
);

  raw_pix_if raw_bus ();
  rgb_if     rgb_bus ();

  logic              eof;
  raw_pix_t          chan_sel  [NUM_CH];
  window_t           win_sel   [NUM_CH];
  chan8_t            ch_value  [NUM_CH];
  logic [NUM_CH-1:0] ch_in_win;

  // ====================
  // Capture and Bayer merge
  // ====================
  pixel_capture cap_i (
    .CLOCK_50   (CLOCK_50),
    .rst_n      (rst_n),
    .cam_pix    (cam_pix),
    .cam_lval   (cam_lval),
    .cam_fval   (cam_fval),
    .capture_en (capture_en),
    .raw        (raw_bus),
    .eof        (eof)
  );

  bayer_to_rgb bayer_i (
    .CLOCK_50 (CLOCK_50),
    .rst_n    (rst_n),
    .raw      (raw_bus),
    .rgb      (rgb_bus)
  );

  // ====================
  // Channel windows
  // ====================
  assign chan_sel[0] = rgb_bus.red;
  assign chan_sel[1] = rgb_bus.green;
  assign chan_sel[2] = rgb_bus.blue;
  assign win_sel[0]  = '{lo: red_lo,   hi: red_hi};
  assign win_sel[1]  = '{lo: green_lo, hi: green_hi};
  assign win_sel[2]  = '{lo: blue_lo,  hi: blue_hi};

  for (genvar i = 0; i < NUM_CH; i++) begin : g_win
    channel_window win_i (
      .CLOCK_50 (CLOCK_50),
      .rst_n    (rst_n),
      .chan     (chan_sel[i]),
      .valid    (rgb_bus.valid),
      .win      (win_sel[i]),
      .value    (ch_value[i]),
      .in_win   (ch_in_win[i])
    );
  end

  pixel_classifier cls_i (
    .CLOCK_50   (CLOCK_50),
    .rst_n      (rst_n),
    .rgb        (rgb_bus),
    .value      (ch_value),
    .in_win     (ch_in_win),
    .gray       (gray),
    .gray_valid (gray_valid),
    .bin8       (bin8),
    .bin_valid  (bin_valid)
  );

  rate_meter #(
    .TICKS (TICKS)
  ) rate_i (
    .CLOCK_50  (CLOCK_50),
    .rst_n     (rst_n),
    .eof       (eof),
    .rate      (rate),
    .pulse_led (pulse_led)
  );

  // RGB exports straight off the merge stage
  assign rgb_red   = rgb_bus.red;
  assign rgb_green = rgb_bus.green;
  assign rgb_blue  = rgb_bus.blue;
  assign rgb_valid = rgb_bus.valid;

endmodule

`default_nettype wire

/* tb/uvispace_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uvispace_cfg.svh"

module uvispace_checker (
  input  wire               CLOCK_50,
  input  wire               rst_n,
  input  wire [`PIX_W-1:0]  cam_pix,
  input  wire               cam_lval,
  input  wire               cam_fval,
  input  wire               capture_en,
  input  wire [`CH_W-1:0]   red_lo,
  input  wire [`CH_W-1:0]   red_hi,
  input  wire [`CH_W-1:0]   green_lo,
  input  wire [`CH_W-1:0]   green_hi,
  input  wire [`CH_W-1:0]   blue_lo,
  input  wire [`CH_W-1:0]   blue_hi,
  input  wire [`PIX_W-1:0]  rgb_red,
  input  wire [`PIX_W-1:0]  rgb_green,
  input  wire [`PIX_W-1:0]  rgb_blue,
  input  wire               rgb_valid,
  input  wire [`CH_W-1:0]   gray,
  input  wire               gray_valid,
  input  wire [`CH_W-1:0]   bin8,
  input  wire               bin_valid,
  input  wire [`RATE_W-1:0] rate,
  input  wire               pulse_led,
  input  int                exp_blocks,   // From the frame table
  input  wire               run_done,
  output int                checks,
  output int                errors,
  output logic              report_ready
);

  logic [`PIX_W-1:0]   line_row [`MAX_WIDTH];   // Even row seen on the pins
  logic [`PIX_W-1:0]   blue_h;
  logic [3*`PIX_W-1:0] rgb_exp [$];             // {red, green, blue}
  logic [2*`CH_W-1:0]  cls_exp [$];             // {gray, bin8}
  logic [`COL_W-1:0]   col = '0;
  logic                fval_p = 1'b0;
  logic                lval_p = 1'b0;
  logic                row_odd = 1'b0;
  logic                live = 1'b0;
  logic                led_p = 1'b0;
  int                  falls = 0;               // cam_fval falling edges
  int                  falls_mark = 0;          // falls at the last LED toggle
  int                  toggles = 0;
  int                  rgb_seen = 0;
  int                  cls_seen = 0;

  initial begin
    checks       = 0;
    errors       = 0;
    report_ready = 1'b0;
  end

  function automatic logic in_window(input int v, input logic [`CH_W-1:0] lo, hi);
    return (v >= int'(lo)) && (v <= int'(hi));   // Both ends count
  endfunction

  task automatic note_fail(input string msg);
    errors++;
    $display("Fail at %0t: %s", $time, msg);
  endtask

  task automatic compare_value(input string name, input logic [31:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // Expected outputs of one 2x2 block
  task automatic predict_block(input logic [`PIX_W-1:0] g1, r, g2, b);
    int  green;
    int  r8, g8, b8;
    logic hit;
    green = (int'(g1) + int'(g2)) / 2;
    r8    = int'(r) >> (`PIX_W - `CH_W);
    g8    = green >> (`PIX_W - `CH_W);
    b8    = int'(b) >> (`PIX_W - `CH_W);
    hit   = in_window(r8, red_lo, red_hi) && in_window(g8, green_lo, green_hi) &&
            in_window(b8, blue_lo, blue_hi);
    rgb_exp.push_back({r, `PIX_W'(green), b});
    cls_exp.push_back({`CH_W'((r8 + 2 * g8 + b8) / 4), hit ? {`CH_W{1'b1}} : {`CH_W{1'b0}}});
  endtask

  // ====================
  // Input side model
  // ====================
  always @(posedge CLOCK_50) begin
    if (!rst_n) begin
      fval_p  = 1'b0;
      lval_p  = 1'b0;
      row_odd = 1'b0;
      live    = 1'b0;
      col     = '0;
      falls   = 0;
    end else begin
      if (cam_fval && !fval_p) begin
        live    = (falls >= `SYNC_FRAMES);   // Only after the sync frames
        row_odd = 1'b0;
      end
      if (!cam_fval && fval_p)
        falls++;
      if (cam_fval && cam_lval) begin
        if (!row_odd)
          line_row[col] = cam_pix;
        else if (!col[0])
          blue_h = cam_pix;
        else if (live && capture_en)
          predict_block(line_row[col - 1'b1], line_row[col], cam_pix, blue_h);
        col = col + 1'b1;
      end
      if (!cam_lval && lval_p) begin
        row_odd = ~row_odd;
        col     = '0;
      end
      fval_p = cam_fval;
      lval_p = cam_lval;
    end
  end

  // ====================
  // Output side checks
  // ====================
  always @(negedge CLOCK_50) begin : check_outputs
    logic [3*`PIX_W-1:0] rgb_e;
    logic [2*`CH_W-1:0]  cls_e;
    int                  diff;
    if (!rst_n) begin
      checks++;
      if ({rgb_valid, gray_valid, bin_valid, pulse_led} !== 4'b0000)
        note_fail("valid strobes and pulse_led not low in reset");
      led_p      = 1'b0;
      falls_mark = 0;
    end else begin
      if ($isunknown({rgb_valid, gray_valid, bin_valid, pulse_led}))
        note_fail("unknown value on a strobe or pulse_led");
      if (gray_valid !== bin_valid)
        note_fail("gray_valid and bin_valid differ");
      if (rgb_valid === 1'b1) begin
        rgb_seen++;
        if (rgb_exp.size() == 0) begin
          note_fail("rgb_valid with no block pending");
        end else begin
          rgb_e = rgb_exp.pop_front();
          compare_value("rgb_red", 32'(rgb_red), 32'(rgb_e[2*`PIX_W +: `PIX_W]));
          compare_value("rgb_green", 32'(rgb_green), 32'(rgb_e[`PIX_W +: `PIX_W]));
          compare_value("rgb_blue", 32'(rgb_blue), 32'(rgb_e[0 +: `PIX_W]));
        end
      end
      if (gray_valid === 1'b1) begin
        cls_seen++;
        if (cls_exp.size() == 0) begin
          note_fail("gray_valid with no block pending");
        end else begin
          cls_e = cls_exp.pop_front();
          compare_value("gray", 32'(gray), 32'(cls_e[`CH_W +: `CH_W]));
          compare_value("bin8", 32'(bin8), 32'(cls_e[0 +: `CH_W]));
        end
      end
      // Rate latched with each LED toggle, one frame of slack at the edges
      if (pulse_led !== led_p) begin
        toggles++;
        checks++;
        diff = int'(rate) - (falls - falls_mark);
        if (diff > 1 || diff < -1) begin
          errors++;
          $display("Fail at %0t: rate is %0d, counted %0d frame ends", $time, rate,
                   falls - falls_mark);
        end
        falls_mark = falls;
        led_p      = pulse_led;
      end
    end
  end

  // End of run totals
  always @(posedge run_done) begin
    checks += 4;
    if (rgb_seen != exp_blocks) begin
      errors++;
      $display("RGB pixel count is %0d, the frame table gives %0d", rgb_seen, exp_blocks);
    end
    if (cls_seen != exp_blocks) begin
      errors++;
      $display("Gray pixel count is %0d, the frame table gives %0d", cls_seen, exp_blocks);
    end
    if (rgb_exp.size() + cls_exp.size() != 0) begin
      errors++;
      $display("%0d predicted outputs never came out", rgb_exp.size() + cls_exp.size());
    end
    if (toggles < 2) begin
      errors++;
      $display("pulse_led toggled %0d times, two rate windows were expected", toggles);
    end
    report_ready = 1'b1;
  end

endmodule

`default_nettype wire

/* tb/tb_uvispace.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uvispace_cfg.svh"

module tb_uvispace;

  localparam int CLK_HALF   = 5;      // 10 ns period
  localparam int RST_CYCLES = 10;
  localparam int NF         = 6;      // Frames in the table
  localparam int LINE_GAP   = 4;
  localparam int FRAME_GAP  = 520;    // Long enough for two rate windows over the run
  localparam int FRAME_CYC  = 2 + 2 * (8 + LINE_GAP) + FRAME_GAP;
  localparam int TICKS      = 2000;

  // Four 2x2 blocks per frame, block 3 in the top bits
  typedef struct packed {
    logic [3:0][`PIX_W-1:0] g1;
    logic [3:0][`PIX_W-1:0] r;
    logic [3:0][`PIX_W-1:0] b;
    logic [3:0][`PIX_W-1:0] g2;
    logic [`CH_W-1:0]       r_lo, r_hi, g_lo, g_hi, b_lo, b_hi;
    logic                   en;
  } frame_t;

  frame_t frame_tab [NF];

  logic               CLOCK_50;
  logic               rst_n;
  logic [`PIX_W-1:0]  cam_pix;
  logic               cam_lval, cam_fval, capture_en;
  logic [`CH_W-1:0]   red_lo, red_hi, green_lo, green_hi, blue_lo, blue_hi;
  logic [`PIX_W-1:0]  rgb_red, rgb_green, rgb_blue;
  logic               rgb_valid, gray_valid, bin_valid, pulse_led;
  logic [`CH_W-1:0]   gray, bin8;
  logic [`RATE_W-1:0] rate;
  int                 exp_blocks;
  int                 checks, errors;
  logic               run_done, report_ready;

  uvispace_top #(.TICKS(TICKS)) dut_i (.*);

  uvispace_checker chk_i (.*);   // Does all the comparing

  always #CLK_HALF CLOCK_50 = ~CLOCK_50;

  // Raw sample at a given row and column of a frame
  function automatic logic [`PIX_W-1:0] pick_sample(input frame_t f, input logic row,
                                                    input logic [2:0] col);
    logic [1:0] blk;
    blk = col[2:1];
    if (!row)
      return col[0] ? f.r[blk] : f.g1[blk];      // G1 R row
    return col[0] ? f.g2[blk] : f.b[blk];        // B G2 row
  endfunction

  // ====================
  // One frame on the camera pins
  // ====================
  task automatic play_frame(input frame_t f);
    @(negedge CLOCK_50);
    {red_lo, red_hi, green_lo, green_hi, blue_lo, blue_hi} =
      {f.r_lo, f.r_hi, f.g_lo, f.g_hi, f.b_lo, f.b_hi};
    capture_en = f.en;
    cam_fval   = 1'b1;
    @(negedge CLOCK_50);
    for (int row = 0; row < 2; row++) begin
      for (int c = 0; c < 8; c++) begin
        @(negedge CLOCK_50);
        cam_lval = 1'b1;
        cam_pix  = pick_sample(f, 1'(row), 3'(c));
      end
      @(negedge CLOCK_50);
      cam_lval = 1'b0;
      repeat (LINE_GAP - 1) @(negedge CLOCK_50);
    end
    cam_fval = 1'b0;                             // Frame end
    repeat (FRAME_GAP) @(negedge CLOCK_50);
  endtask

  initial begin
    CLOCK_50   = 1'b0;
    rst_n      = 1'b0;
    cam_pix    = '0;
    cam_lval   = 1'b0;
    cam_fval   = 1'b0;
    capture_en = 1'b0;
    {red_lo, red_hi, green_lo, green_hi, blue_lo, blue_hi} = '0;
    run_done   = 1'b0;

    // G1, R, B, G2 (block 3 first), then R/G/B lo,hi windows, capture_en
    frame_tab[0] = {48'h123_456_789_ABC, 48'hFED_CBA_987_654, 48'h0F0_1E1_2D2_3C3,
                    48'h321_654_987_CBA, 48'h00FF_00FF_00FF, 1'b1};
    frame_tab[1] = {48'h555_444_333_222, 48'h810_3FF_80F_400, 48'h111_222_333_444,
                    48'h666_555_444_333, 48'h4080_00FF_00FF, 1'b1};   // Red at lo and hi
    frame_tab[2] = {48'hAAA_BBB_CCC_DDD, 48'h111_222_333_444, 48'h999_888_777_666,
                    48'h555_444_333_222, 48'h00FF_00FF_00FF, 1'b0};   // Capture off
    frame_tab[3] = {48'hA10_5FE_A00_600, 48'h777_888_999_AAA, 48'h1FF_7FF_C0F_200,
                    48'hA10_600_A1F_600, 48'h00FF_60A0_20C0, 1'b1};   // Green, blue edges
    frame_tab[4] = {48'hFFF_000_FFF_001, 48'hFFF_000_FFF_000, 48'h000_FFF_FFF_000,
                    48'hFFF_000_001_FFF, 48'hFFFF_00FF_00FF, 1'b1};   // Extremes
    frame_tab[5] = {48'h7F0_800_800_800, 48'h808_7FF_808_808, 48'h80A_80A_90A_80A,
                    48'h800_800_800_81F, 48'h8080_8080_8080, 1'b1};   // Single-value windows

    exp_blocks = 0;
    foreach (frame_tab[i])
      if (frame_tab[i].en)
        exp_blocks += 4;

    repeat (RST_CYCLES) @(negedge CLOCK_50);
    rst_n = 1'b1;

    repeat (`SYNC_FRAMES) play_frame(frame_tab[0]);   // Dropped by frame sync
    for (int i = 0; i < NF; i++)
      play_frame(frame_tab[i]);

    run_done = 1'b1;
    wait (report_ready === 1'b1);
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // Watchdog, twice the whole frame sequence
  initial begin
    #((`SYNC_FRAMES + NF) * FRAME_CYC * 2 * 2 * CLK_HALF);
    $display("Watchdog timeout, the frame sequence did not complete");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* uvispace_top.f */
+incdir+hdl
hdl/video_pkg.sv
hdl/ctrl_pkg.sv
hdl/video_if.sv
hdl/pixel_capture.sv
hdl/bayer_to_rgb.sv
hdl/channel_window.sv
hdl/pixel_classifier.sv
hdl/rate_meter.sv
hdl/uvispace_top.sv
tb/uvispace_checker.sv
tb/tb_uvispace.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_uvispace
FILELIST  ?= uvispace_top.f
BUILD_DIR ?= obj_dir
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
